//--- bench/lsu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_properties (
  input wire logic             clk,
  input wire logic             resetn,
  input wire logic             fetch_en,
  input wire logic             mem_access,
  input wire logic             rd_en,
  input wire logic             wr_en,
  input wire lsu_pkg::region_e region
);

  import lsu_pkg::*;

  int fail_count = 0;   // assertion failures so far

  ////////////////////
  // port levels
  ////////////////////

  property rd_wr_exclusive;
    @(posedge clk) disable iff (!resetn)
      !(rd_en && wr_en);
  endproperty

  property fetch_access_exclusive;
    @(posedge clk) disable iff (!resetn)
      !(fetch_en && mem_access);
  endproperty

  // pram answers in a single cycle
  property pram_one_cycle;
    @(posedge clk) disable iff (!resetn)
      (mem_access && (region == REGION_PRAM)) |=> !mem_access;
  endproperty

  rd_wr_check: assert property (rd_wr_exclusive) else begin
    fail_count++;
    $error("rd_en and wr_en are high together");
  end

  fetch_access_check: assert property (fetch_access_exclusive) else begin
    fail_count++;
    $error("fetch_en and mem_access are high together");
  end

  pram_access_check: assert property (pram_one_cycle) else begin
    fail_count++;
    $error("pram access lasted more than one cycle");
  end

endmodule

`default_nettype wire

//--- bench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module lsu_tb;

  import rv_isa_pkg::*;

  localparam int N_DIRECTED  = 13;
  localparam int N_RANDOM    = 30;
  localparam int CYCLE_LIMIT = 40 * (N_DIRECTED + N_RANDOM) + 100;

  logic             clk;
  logic             resetn;
  logic [`XLEN-1:0] instr;
  logic             fetch_valid;
  logic [`XLEN-1:0] rs1_value;
  logic [`XLEN-1:0] rs2_value;
  logic             halt_ack;
  logic             pram_load_done;
  logic             fetch_en;
  logic             mem_access;
  logic             rd_en;
  logic             wr_en;
  mem_size_e        mem_size;
  logic [`XLEN-1:0] ls_addr;
  logic [`XLEN-1:0] ls_wdata;

  // expected outputs after the latest rising edge
  logic             exp_fetch;
  logic             exp_access;
  logic             exp_rd;
  logic             exp_wr;
  logic [1:0]       exp_size;
  logic [`XLEN-1:0] exp_addr;
  logic [`XLEN-1:0] exp_wdata;

  logic             checking = 1'b0;
  int               n_checks = 0;
  int               n_errors = 0;
  int               cycles   = 0;
  logic [31:0]      lfsr_state = 32'h59c0;

  lsu_top u_lsu_top (
    .clk            (clk),
    .resetn         (resetn),
    .instr          (instr),
    .fetch_valid    (fetch_valid),
    .rs1_value      (rs1_value),
    .rs2_value      (rs2_value),
    .halt_ack       (halt_ack),
    .pram_load_done (pram_load_done),
    .fetch_en       (fetch_en),
    .mem_access     (mem_access),
    .rd_en          (rd_en),
    .wr_en          (wr_en),
    .mem_size       (mem_size),
    .ls_addr        (ls_addr),
    .ls_wdata       (ls_wdata)
  );

  bind mem_access_fsm lsu_properties u_lsu_properties (
    .clk        (clk),
    .resetn     (resetn),
    .fetch_en   (fetch_en),
    .mem_access (mem_access),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .region     (region)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};   // one step per bit
    end
  endtask

  // op_sel 0 load, 1 store, 2 alu immediate, 3 alu register
  function automatic logic [31:0] build_instr(input logic [1:0] op_sel,
                                              input logic [2:0] funct3,
                                              input logic [11:0] imm);
    case (op_sel)
      2'd0:    return {imm, 5'd1, funct3, 5'd2, OP_LOAD};
      2'd1:    return {imm[11:5], 5'd3, 5'd1, funct3, imm[4:0], OP_STORE};
      2'd2:    return {imm, 5'd1, funct3, 5'd2, OP_IMM};
      default: return {7'b0, 5'd3, 5'd1, funct3, 5'd2, OP_REG};
    endcase
  endfunction

  // expected access from the load/store rules
  function automatic void ref_access(input  logic [`XLEN-1:0] ins,
                                     input  logic [`XLEN-1:0] rs1,
                                     input  logic [`XLEN-1:0] rs2,
                                     output logic             is_mem,
                                     output logic             is_store,
                                     output logic [`XLEN-1:0] addr,
                                     output logic [`XLEN-1:0] data,
                                     output logic [1:0]       size,
                                     output logic             ext);
    logic [`OFFSET_W-1:0] imm;
    is_store = (ins[6:0] == OP_STORE);
    is_mem   = is_store || (ins[6:0] == OP_LOAD);
    imm      = is_store ? {ins[31:25], ins[11:7]} : ins[31:20];
    addr     = rs1 + {{(`XLEN-`OFFSET_W){imm[`OFFSET_W-1]}}, imm};
    data     = is_store ? rs2 : '0;
    case (ins[13:12])
      2'b00:   size = SIZE_BYTE;
      2'b01:   size = SIZE_HALF;
      default: size = SIZE_WORD;
    endcase
    ext = |addr[`REGION_MSB:`REGION_LSB];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAIL at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic expect_fetch();
    exp_fetch  = 1'b1;
    exp_access = 1'b0;
    exp_rd     = 1'b1;
    exp_wr     = 1'b0;
    exp_size   = SIZE_WORD;
  endtask

  // one fetched word, and the access it starts if it is a load or store
  task automatic run_instr(input logic [1:0] op_sel, input logic [2:0] funct3,
                           input logic ext, input int wait_cycles);
    logic [31:0]      imm_r;
    logic [31:0]      region_r;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
    logic [`XLEN-1:0] ins;
    logic [`XLEN-1:0] e_addr;
    logic [`XLEN-1:0] e_data;
    logic [1:0]       e_size;
    logic             is_mem;
    logic             is_store;
    logic             e_ext;
    rand_bits(12, imm_r);
    rand_bits(32, target);
    rand_bits(3, region_r);
    rand_bits(32, rs2);
    if (!ext) begin
      target[`REGION_MSB:`REGION_LSB] = 3'b000;
    end else if (region_r[2:0] == 3'b000) begin
      target[`REGION_MSB:`REGION_LSB] = 3'b101;
    end else begin
      target[`REGION_MSB:`REGION_LSB] = region_r[2:0];
    end
    // pick rs1 so that rs1 plus offset lands on the target
    rs1 = target - {{(`XLEN-`OFFSET_W){imm_r[11]}}, imm_r[11:0]};
    ins = build_instr(op_sel, funct3, imm_r[11:0]);
    @(posedge clk);
    instr       <= ins;
    fetch_valid <= 1'b1;
    rs1_value   <= rs1;
    rs2_value   <= rs2;
    @(posedge clk);
    fetch_valid <= 1'b0;
    ref_access(ins, rs1, rs2, is_mem, is_store, e_addr, e_data, e_size, e_ext);
    if (is_mem) begin
      exp_fetch  = 1'b0;
      exp_access = 1'b1;
      exp_rd     = !is_store;
      exp_wr     = is_store;
      exp_size   = e_size;
      exp_addr   = e_addr;
      exp_wdata  = e_data;
      if (e_ext) begin
        repeat (wait_cycles) @(posedge clk);   // access held
        halt_ack <= 1'b1;
        @(posedge clk);
        halt_ack <= 1'b0;
      end else begin
        @(posedge clk);
      end
      expect_fetch();
    end
  endtask

  ////////////////////
  // compare
  ////////////////////

  always @(negedge clk) begin
    if (checking) begin
      check_value("fetch_en", fetch_en, exp_fetch);
      check_value("mem_access", mem_access, exp_access);
      check_value("rd_en", rd_en, exp_rd);
      check_value("wr_en", wr_en, exp_wr);
      check_value("mem_size", mem_size, exp_size);
      check_value("ls_addr", ls_addr, exp_addr);
      check_value("ls_wdata", ls_wdata, exp_wdata);
    end
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0] r_sel;
    logic [31:0] r_f3;
    logic [31:0] r_ext;
    logic [31:0] r_wait;
    resetn         = 1'b0;
    instr          = '0;
    fetch_valid    = 1'b0;
    rs1_value      = '0;
    rs2_value      = '0;
    halt_ack       = 1'b0;
    pram_load_done = 1'b0;
    exp_fetch      = 1'b0;
    exp_access     = 1'b0;
    exp_rd         = 1'b0;
    exp_wr         = 1'b0;
    exp_size       = SIZE_WORD;
    exp_addr       = '0;
    exp_wdata      = '0;
    @(posedge clk);
    checking = 1'b1;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    repeat (4) @(posedge clk);   // idle while program RAM still loads
    pram_load_done <= 1'b1;
    @(posedge clk);
    expect_fetch();
    // sizes on pram loads and stores
    for (int f = 0; f < 4; f++) begin
      run_instr(2'd0, f[2:0], 1'b0, 0);
    end
    for (int f = 0; f < 3; f++) begin
      run_instr(2'd1, f[2:0], 1'b0, 0);
    end
    run_instr(2'd2, 3'b000, 1'b0, 0);
    // external region with back-pressure
    run_instr(2'd0, 3'b010, 1'b1, 3);
    run_instr(2'd1, 3'b000, 1'b1, 5);
    run_instr(2'd0, 3'b001, 1'b1, 0);
    run_instr(2'd1, 3'b010, 1'b1, 7);
    run_instr(2'd3, 3'b000, 1'b1, 0);
    for (int i = 0; i < N_RANDOM; i++) begin
      rand_bits(2, r_sel);
      rand_bits(3, r_f3);
      rand_bits(1, r_ext);
      rand_bits(3, r_wait);
      run_instr(r_sel[1:0], r_f3[2:0], r_ext[0], int'(r_wait[2:0]));
    end
    repeat (2) @(posedge clk);
    n_errors += u_lsu_top.u_mem_access_fsm.u_lsu_properties.fail_count;
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

////////////////////
// rv32 widths
////////////////////

`define XLEN       32     // data and address width
`define REG_IDX_W  5      // register index and the split imm field in s-type
`define OFFSET_W   12     // i-type and s-type immediate

////////////////////
// memory map
////////////////////

// any of these address bits set selects the external region
`define REGION_LSB 14
`define REGION_MSB 16

// word size code on the port after reset
`define RESET_SIZE 2'b10

`endif

//--- logic/ls_agu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module ls_agu (
  input  wire logic                  clk,
  input  wire logic                  resetn,
  input  wire logic                  capture,
  input  wire lsu_pkg::ls_kind_e     kind,
  input  wire logic      [`XLEN-1:0] offset,
  input  wire rv_isa_pkg::mem_size_e size,
  input  wire logic      [`XLEN-1:0] rs1_value,
  input  wire logic      [`XLEN-1:0] rs2_value,
  output logic           [`XLEN-1:0] addr,
  output logic           [`XLEN-1:0] wdata,
  output rv_isa_pkg::mem_size_e      acc_size,
  output lsu_pkg::ls_kind_e          acc_kind,
  output lsu_pkg::region_e           region
);

  import rv_isa_pkg::*;
  import lsu_pkg::*;

  logic [`XLEN-1:0] eff_addr;
  logic [`XLEN-1:0] store_data;

  ////////////////////
  // effective address
  ////////////////////

  assign eff_addr   = rs1_value + offset;   // wraps like the core adder
  assign store_data = (kind == KIND_STORE) ? rs2_value : '0;   // loads drive zero

  // cleared by reset and loaded only on capture
  always_ff @(posedge clk) begin
    if (!resetn) begin
      addr     <= '0;
      wdata    <= '0;
      acc_size <= mem_size_e'(`RESET_SIZE);
      acc_kind <= KIND_NONE;
    end else if (capture) begin
      addr     <= eff_addr;
      wdata    <= store_data;
      acc_size <= size;
      acc_kind <= kind;
    end
  end

  ////////////////////
  // region
  ////////////////////

  // taken from the held address so it is stable for the whole access
  assign region = (|addr[`REGION_MSB:`REGION_LSB]) ? REGION_EXT : REGION_PRAM;

endmodule

`default_nettype wire

//--- logic/ls_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module ls_decode (
  input  wire logic [`XLEN-1:0] instr,
  output lsu_pkg::ls_kind_e      kind,
  output logic      [`XLEN-1:0] offset,
  output rv_isa_pkg::mem_size_e  size
);

  import rv_isa_pkg::*;
  import lsu_pkg::*;

  opcode_e               opcode;
  logic [`REG_IDX_W-1:0] imm_low;   // sits in rd field for stores, rs2 field for loads
  logic [`OFFSET_W-1:0]  imm;

  assign opcode = opcode_e'(instr[6:0]);

  ////////////////////
  // classify
  ////////////////////

  always_comb begin
    case (opcode)
      OP_LOAD:  kind = KIND_LOAD;
      OP_STORE: kind = KIND_STORE;
      default:  kind = KIND_NONE;   // alu, branch, etc
    endcase
  end

  ////////////////////
  // immediate
  ////////////////////

  // upper seven bits are shared by i-type and s-type
  assign imm_low = (opcode == OP_STORE) ? instr[7 +: `REG_IDX_W] : instr[20 +: `REG_IDX_W];
  assign imm     = {instr[31:25], imm_low};

  assign offset = {{(`XLEN-`OFFSET_W){imm[`OFFSET_W-1]}}, imm};

  // funct3[1:0] only since the unsigned bit does not change the port size
  always_comb begin
    case (instr[13:12])
      2'b00:   size = SIZE_BYTE;
      2'b01:   size = SIZE_HALF;
      default: size = SIZE_WORD;    // lw with 11 folded onto word
    endcase
  end

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // memory port sequencer
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,  // waiting for pram load
    ST_FETCH  = 2'b01,
    ST_ACCESS = 2'b10
  } seq_state_e;

  typedef enum logic [1:0] {
    KIND_NONE  = 2'b00,
    KIND_LOAD  = 2'b01,
    KIND_STORE = 2'b10
  } ls_kind_e;

  // one cycle pram or halt_ack paced external bus
  typedef enum logic {
    REGION_PRAM = 1'b0,
    REGION_EXT  = 1'b1
  } region_e;

endpackage

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module lsu_top (
  input  wire logic                  clk,
  input  wire logic                  resetn,
  input  wire logic      [`XLEN-1:0] instr,
  input  wire logic                  fetch_valid,
  input  wire logic      [`XLEN-1:0] rs1_value,
  input  wire logic      [`XLEN-1:0] rs2_value,
  input  wire logic                  halt_ack,
  input  wire logic                  pram_load_done,
  output logic                       fetch_en,
  output logic                       mem_access,
  output logic                       rd_en,
  output logic                       wr_en,
  output rv_isa_pkg::mem_size_e      mem_size,
  output logic           [`XLEN-1:0] ls_addr,
  output logic           [`XLEN-1:0] ls_wdata
);

  import rv_isa_pkg::*;
  import lsu_pkg::*;

  ////////////////////
  // decode to agu/fsm
  ////////////////////

  ls_kind_e         kind;
  logic [`XLEN-1:0] offset;
  mem_size_e        size;

  // agu to fsm
  ls_kind_e         acc_kind;
  mem_size_e        acc_size;
  region_e          region;
  logic             capture;

  ls_decode u_ls_decode (
    .instr  (instr),
    .kind   (kind),
    .offset (offset),
    .size   (size)
  );

  ls_agu u_ls_agu (
    .clk       (clk),
    .resetn    (resetn),
    .capture   (capture),
    .kind      (kind),
    .offset    (offset),
    .size      (size),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .addr      (ls_addr),     // held between accesses
    .wdata     (ls_wdata),
    .acc_size  (acc_size),
    .acc_kind  (acc_kind),
    .region    (region)
  );

  mem_access_fsm u_mem_access_fsm (
    .clk            (clk),
    .resetn         (resetn),
    .pram_load_done (pram_load_done),
    .fetch_valid    (fetch_valid),
    .halt_ack       (halt_ack),
    .kind           (kind),
    .acc_kind       (acc_kind),
    .acc_size       (acc_size),
    .region         (region),
    .capture        (capture),
    .fetch_en       (fetch_en),
    .mem_access     (mem_access),
    .rd_en          (rd_en),
    .wr_en          (wr_en),
    .mem_size       (mem_size)
  );

endmodule

`default_nettype wire

//--- logic/mem_access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_fsm (
  input  wire logic                  clk,
  input  wire logic                  resetn,
  input  wire logic                  pram_load_done,
  input  wire logic                  fetch_valid,
  input  wire logic                  halt_ack,
  input  wire lsu_pkg::ls_kind_e     kind,
  input  wire lsu_pkg::ls_kind_e     acc_kind,
  input  wire rv_isa_pkg::mem_size_e acc_size,
  input  wire lsu_pkg::region_e      region,
  output logic                       capture,
  output logic                       fetch_en,
  output logic                       mem_access,
  output logic                       rd_en,
  output logic                       wr_en,
  output rv_isa_pkg::mem_size_e      mem_size
);

  import rv_isa_pkg::*;
  import lsu_pkg::*;

  seq_state_e state;
  seq_state_e next_state;
  ls_kind_e   next_kind;     // kind that the port will carry after this edge
  logic       access_done;

  // accept a load or store only while fetching
  assign capture = (state == ST_FETCH) && fetch_valid && (kind != KIND_NONE);

  // pram answers in one cycle, external waits for the ack strobe
  assign access_done = (region == REGION_PRAM) || halt_ack;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (pram_load_done) begin
          next_state = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (capture) begin
          next_state = ST_ACCESS;
        end
      end
      ST_ACCESS: begin
        if (access_done) begin
          next_state = ST_FETCH;
        end
      end
      default: next_state = ST_IDLE;
    endcase
  end

  // agu loads on the same edge, so use the decoder's kind there
  assign next_kind = capture ? kind : acc_kind;

  ////////////////////
  // state and levels
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= ST_IDLE;
      fetch_en   <= 1'b0;
      mem_access <= 1'b0;
      rd_en      <= 1'b0;
      wr_en      <= 1'b0;
    end else begin
      state      <= next_state;
      fetch_en   <= (next_state == ST_FETCH);
      mem_access <= (next_state == ST_ACCESS);
      // fetch reads the instruction word
      rd_en      <= (next_state == ST_FETCH) ||
                    ((next_state == ST_ACCESS) && (next_kind == KIND_LOAD));
      wr_en      <= (next_state == ST_ACCESS) && (next_kind == KIND_STORE);
    end
  end

  // word during fetch and idle, captured size during the access
  assign mem_size = (state == ST_ACCESS) ? acc_size : SIZE_WORD;

endmodule

`default_nettype wire

//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  ////////////////////
  // major opcodes
  ////////////////////

  // only load and store matter to the controller, the rest are seen as alu traffic
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  ////////////////////
  // memory port size
  ////////////////////

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } mem_size_e;

endpackage

`default_nettype wire

//--- verilog.f
+incdir+include
logic/rv_isa_pkg.sv
logic/lsu_pkg.sv
logic/ls_decode.sv
logic/ls_agu.sv
logic/mem_access_fsm.sv
logic/lsu_top.sv
bench/lsu_properties.sv
bench/lsu_tb.sv
